//--- dv/tb_cpuhandler.sv
// testbench for tt_um_cpuhandler with memory model, reference cpu model and frame decoder

`timescale 1ns/1ps
`default_nettype none

`include "cpuh_defines.svh"

module tb_cpuhandler;

  import cpuh_pkg::*;

  typedef struct packed {
    logic [63:0] pc;
    logic [63:0] acc;
    logic        opnd;    // waiting for an operand frame
    logic        op_add;
    bus_req_t    req;     // request expected in the coming frame
  } model_t;

  logic clk;
  logic arst_n;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic ena;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [63:0] mem [0:63];
  model_t      model;
  integer      seed;
  integer      req_errs;
  integer      oe_errs;
  integer      word_errs;
  integer      pin_errs;
  logic        done = 1'b0;

  tt_um_cpuhandler tt_um_cpuhandler_inst (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .arst_n  (arst_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // overall limit on run length
  initial begin
    integer n;
    for (n = 0; n < 4000 && !done; n = n + 1) @(posedge clk);
    if (!done) begin
      $display("simulation did not finish within 4000 clock cycles");
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] mk_insn(input logic [7:0] op, input logic [55:0] opnd);
    return {op, opnd};
  endfunction

  // expected cpu behavior for one frame, given the word read in that frame
  function automatic model_t ref_step(input model_t m, input logic [63:0] rword);
    model_t      n;
    insn_t       i;
    logic [63:0] target;
    n      = m;
    i      = insn_t'(rword);
    target = {8'b0, i.operand};
    if (!m.opnd) begin
      case (i.opcode)
        OP_LOAD, OP_ADD: begin
          n.op_add = (i.opcode == OP_ADD);
          n.pc     = m.pc + 64'd1;
          n.req    = '{addr: target, wdata: 64'd0, rd: 1'b1};
          n.opnd   = 1'b1;
        end
        OP_STORE: begin
          n.pc   = m.pc + 64'd1;
          n.req  = '{addr: target, wdata: m.acc, rd: 1'b0};
          n.opnd = 1'b1;
        end
        OP_JUMP: begin
          n.pc  = target;
          n.req = '{addr: target, wdata: 64'd0, rd: 1'b1};
        end
        default: begin  // nop
          n.pc  = m.pc + 64'd1;
          n.req = '{addr: m.pc + 64'd1, wdata: 64'd0, rd: 1'b1};
        end
      endcase
    end else begin
      if (m.req.rd) n.acc = m.op_add ? m.acc + rword : rword;
      n.req  = '{addr: m.pc, wdata: 64'd0, rd: 1'b1};
      n.opnd = 1'b0;
    end
    return n;
  endfunction

  task automatic check_req(input bus_req_t exp, input bus_req_t got);
    if (got !== exp) begin
      req_errs = req_errs + 1;
      $display("** Error at %0t: request addr %h wdata %h rd %b, expected addr %h wdata %h rd %b",
               $time, got.addr, got.wdata, got.rd, exp.addr, exp.wdata, exp.rd);
    end
  endtask

  task automatic check_oe(input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      oe_errs = oe_errs + 1;
      $display("** Error at %0t: uio_oe %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_word(input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      word_errs = word_errs + 1;
      $display("** Error at %0t: memory word %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_idle(input logic [7:0] uo, input logic [7:0] uio);
    if (uo !== 8'h00 || uio !== 8'h00) begin
      pin_errs = pin_errs + 1;
      $display("** Error at %0t: idle phase pins uo %h uio %h, expected 0", $time, uo, uio);
    end
  endtask

  task automatic apply_reset();
    integer n;
    @(negedge clk);
    arst_n = 1'b0;
    for (n = 0; n < 8; n = n + 1) @(negedge clk);
    check_idle(uo_out, uio_out);
    check_oe(8'h00, uio_oe);
    arst_n = 1'b1;  // released on a falling edge, count 0 phase
    model  = '0;
    model.req = '{addr: 64'd0, wdata: 64'd0, rd: 1'b1};
  endtask

  // one whole frame, starting after the falling edge of count 0
  task automatic run_frame();
    bus_req_t    obs;
    logic [63:0] rword;
    integer      c;
    integer      nxt;
    obs = '0;
    for (c = 0; c < `CPUH_FRAME_LEN; c = c + 1) begin
      @(posedge clk);
      if (c >= 1 && c <= `CPUH_BUS_BYTES) begin
        obs.addr[(c - 1) * 8 +: 8]  = uo_out;
        obs.wdata[(c - 1) * 8 +: 8] = uio_out;
      end else if (c == `CPUH_PH_DIR) begin
        obs.rd = ~uo_out[0];
        check_idle({uo_out[7:1], 1'b0}, uio_out);
        check_oe(model.req.rd ? 8'h00 : 8'hff, uio_oe);
      end else begin
        check_idle(uo_out, uio_out);
      end
      @(negedge clk);
      nxt = (c + 2) % `CPUH_FRAME_LEN;  // byte must be stable one edge early
      if (nxt >= `CPUH_PH_RD0) uio_in <= mem[obs.addr[5:0]][(nxt - `CPUH_PH_RD0) * 8 +: 8];
      else uio_in <= 8'h00;
    end
    rword = mem[model.req.addr[5:0]];
    check_req(model.req, obs);
    if (!obs.rd) mem[obs.addr[5:0]] = obs.wdata;
    model = ref_step(model, rword);
  endtask

  task automatic run_frames(input integer n);
    integer k;
    for (k = 0; k < n; k = k + 1) run_frame();
  endtask

  initial begin
    integer      a;
    logic [7:0]  ops [0:4];
    req_errs  = 0;
    oe_errs   = 0;
    word_errs = 0;
    pin_errs  = 0;
    seed      = 66237;
    arst_n    = 1'b0;
    ui_in     = 8'h00;
    uio_in    <= 8'h00;
    ena       = 1'b1;
    ops[0] = OP_LOAD;
    ops[1] = OP_ADD;
    ops[2] = OP_STORE;
    ops[3] = OP_JUMP;
    ops[4] = 8'h00;

    // nop sled, top byte 0 everywhere
    for (a = 0; a < 64; a = a + 1) mem[a] = {8'h00, 56'(a) * 56'h0001_0203_0405_07};
    apply_reset();
    run_frames(12);

    // load, add, store with wrap, then a jump loop back to the add
    for (a = 0; a < 64; a = a + 1) mem[a] = {8'h00, 56'(a) * 56'h0011_0000_0013};
    mem[0]  = mk_insn(OP_LOAD, 56'd40);
    mem[1]  = mk_insn(OP_ADD, 56'd41);
    mem[2]  = mk_insn(OP_STORE, 56'd42);
    mem[3]  = mk_insn(OP_JUMP, 56'd1);
    mem[40] = 64'hffff_ffff_ffff_fff0;
    mem[41] = 64'h0000_0000_0000_0025;
    apply_reset();
    run_frames(6);
    check_word(64'h0000_0000_0000_0015, mem[42]);
    run_frames(5);  // jump, add, store
    check_word(64'h0000_0000_0000_003a, mem[42]);
    run_frames(15);

    // random program
    for (a = 0; a < 64; a = a + 1) begin
      mem[a] = mk_insn(ops[$unsigned($random(seed)) % 5], 56'($unsigned($random(seed)) % 64));
    end
    apply_reset();
    run_frames(60);

    done = 1'b1;
    $display("errors: request %0d, uio_oe %0d, memory %0d, idle pins %0d",
             req_errs, oe_errs, word_errs, pin_errs);
    if (req_errs + oe_errs + word_errs + pin_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/acc_cpu.sv
// accumulator cpu with instruction and operand states, one bus request per step

`timescale 1ns/1ps
`default_nettype none

module acc_cpu (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               step,   // end of frame, rdata is complete
  input  logic [63:0]        rdata,
  output cpuh_pkg::bus_req_t req     // held for the next whole frame
);

  import cpuh_pkg::*;

  typedef enum logic {
    ST_INSN,  // rdata holds the next instruction
    ST_OPND   // rdata holds an operand, or a store just went out
  } state_e;

  state_e      state;
  logic [63:0] pc;
  logic [63:0] acc;
  logic        op_add;  // pending operand adds rather than loads
  insn_t       insn;
  logic [63:0] target;  // operand widened to a bus address
  logic [63:0] pc_inc;

  assign insn   = insn_t'(rdata);
  assign target = {8'b0, insn.operand};
  assign pc_inc = pc + 64'd1;

  // plain read request, used for fetches and operand reads
  function automatic bus_req_t read_req(input logic [63:0] addr);
    bus_req_t r;
    r.addr  = addr;
    r.wdata = '0;
    r.rd    = 1'b1;
    return r;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= ST_INSN;
      pc     <= '0;
      acc    <= '0;
      op_add <= 1'b0;
      req    <= read_req('0);  // first fetch at address 0
    end else if (step) begin
      case (state)
        ST_INSN: begin
          case (insn.opcode)
            OP_LOAD, OP_ADD: begin
              op_add <= (insn.opcode == OP_ADD);
              pc     <= pc_inc;
              req    <= read_req(target);
              state  <= ST_OPND;
            end
            OP_STORE: begin
              pc    <= pc_inc;
              req   <= '{addr: target, wdata: acc, rd: 1'b0};
              state <= ST_OPND;
            end
            OP_JUMP: begin
              pc  <= target;
              req <= read_req(target);  // fetch straight at the target
            end
            default: begin  // nop
              pc  <= pc_inc;
              req <= read_req(pc_inc);
            end
          endcase
        end

        ST_OPND: begin
          // after a store the captured bytes are ignored
          if (req.rd) begin
            acc <= op_add ? acc + rdata : rdata;  // wraps mod 2^64
          end
          req   <= read_req(pc);  // pc already points past the insn
          state <= ST_INSN;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/bus_serializer.sv
// byte lane driver for address/write data, direction flag and read data capture

`timescale 1ns/1ps
`default_nettype none

`include "cpuh_defines.svh"

module bus_serializer (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [4:0]         count,
  input  cpuh_pkg::bus_req_t req,
  input  logic [7:0]         uio_in,
  output logic [7:0]         uo_out,
  output logic [7:0]         uio_out,
  output logic [7:0]         uio_oe,
  output logic [63:0]        rdata
);

  logic [2:0] wr_lane;  // byte lane for counts 1..8
  logic [2:0] rd_lane;  // byte lane for counts 10..17

  // least significant byte goes out first
  assign wr_lane = 3'(count - 5'd1);

  // read bytes also arrive least significant first
  assign rd_lane = 3'(count - 5'(`CPUH_PH_RD0));

  // pads drive during write frames, listen during read frames
  assign uio_oe = req.rd ? 8'h00 : 8'hff;

  // Everything changes on the falling edge so the pins are stable around
  // the rising edge, where the outside world samples them. The read bytes
  // are sampled on the same falling edge, so the word is complete before
  // the step edge at the end of the frame.
  always_ff @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uo_out  <= '0;
      uio_out <= '0;
      rdata   <= '0;
    end else begin
      case (count) inside
        // address and write data lanes side by side
        [5'd1:5'(`CPUH_BUS_BYTES)]: begin
          uo_out  <= req.addr[{wr_lane, 3'b000} +: 8];
          uio_out <= req.wdata[{wr_lane, 3'b000} +: 8];
        end

        // direction flag, bit 0 high for a write
        5'(`CPUH_PH_DIR): begin
          uo_out  <= {7'b0, ~req.rd};
          uio_out <= '0;
        end

        // read data phase, outputs idle
        [5'(`CPUH_PH_RD0):5'(`CPUH_PH_LAST)]: begin
          rdata[{rd_lane, 3'b000} +: 8] <= uio_in;
          uo_out                        <= '0;
          uio_out                       <= '0;
        end

        default: begin  // count 0
          uo_out  <= '0;
          uio_out <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/cpuh_defines.svh
// frame length, bus width and frame phase index macros

`ifndef CPUH_DEFINES_SVH
`define CPUH_DEFINES_SVH

// one bus transaction per frame, counts 0 .. 17
`define CPUH_FRAME_LEN 18

// bytes per 64-bit word on the 8-bit pins
`define CPUH_BUS_BYTES 8

// direction flag phase
`define CPUH_PH_DIR 9

// read capture runs from RD0 up to LAST
`define CPUH_PH_RD0 10
`define CPUH_PH_LAST 17

`endif

//--- rtl/cpuh_pkg.sv
// opcode enum, instruction word struct and bus request struct

`default_nettype none

package cpuh_pkg;

  // top byte of an instruction word, any other value runs as a nop
  typedef enum logic [7:0] {
    OP_LOAD  = 8'h01,
    OP_ADD   = 8'h02,
    OP_STORE = 8'h03,
    OP_JUMP  = 8'h04
  } opcode_e;

  // instruction word as fetched over the bus
  typedef struct packed {
    opcode_e     opcode;   // bits 63:56
    logic [55:0] operand;  // word address
  } insn_t;

  // one bus transaction, held for a whole frame
  typedef struct packed {
    logic [63:0] addr;   // word address
    logic [63:0] wdata;  // only meaningful for writes
    logic        rd;     // 1 = read, 0 = write
  } bus_req_t;

endpackage

`default_nettype wire

//--- rtl/frame_counter.sv
// frame counter wrapping at the end of each frame, plus the cpu step strobe

`timescale 1ns/1ps
`default_nettype none

`include "cpuh_defines.svh"

module frame_counter (
  input  logic       clk,
  input  logic       arst_n,
  output logic [4:0] count,  // position inside the frame
  output logic       step    // one cycle, last count of the frame
);

  // cpu advances on the 17 -> 0 wrap edge
  assign step = (count == 5'(`CPUH_PH_LAST));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (count == 5'(`CPUH_FRAME_LEN - 1)) begin
      count <= '0;  // frame done
    end else begin
      count <= count + 5'd1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/tt_um_cpuhandler.sv
// top level connecting frame counter, bus serializer and cpu to the pins

`timescale 1ns/1ps
`default_nettype none

module tt_um_cpuhandler (
  input  logic [7:0] ui_in,    // not used
  output logic [7:0] uo_out,   // address bytes, direction flag
  input  logic [7:0] uio_in,   // read data bytes
  output logic [7:0] uio_out,  // write data bytes
  output logic [7:0] uio_oe,
  input  logic       ena,      // not used
  input  logic       clk,
  input  logic       arst_n
);

  import cpuh_pkg::*;

  logic [4:0]  count;
  logic        step;
  bus_req_t    req;
  logic [63:0] rdata;
  logic        unused_in;

  assign unused_in = &{ena, ui_in, 1'b0};

  frame_counter u_frame_counter (
    .clk    (clk),
    .arst_n (arst_n),
    .count  (count),
    .step   (step)
  );

  bus_serializer u_bus_serializer (
    .clk     (clk),
    .arst_n  (arst_n),
    .count   (count),
    .req     (req),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .rdata   (rdata)
  );

  acc_cpu u_acc_cpu (
    .clk    (clk),
    .arst_n (arst_n),
    .step   (step),
    .rdata  (rdata),
    .req    (req)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_cpuhandler -o tb_sim \
  > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

//--- sources.f
+incdir+rtl
rtl/cpuh_pkg.sv
rtl/frame_counter.sv
rtl/bus_serializer.sv
rtl/acc_cpu.sv
rtl/tt_um_cpuhandler.sv
dv/tb_cpuhandler.sv
